// File: logic/lq_pkg.sv
package lq_pkg;

    typedef logic [4:0]  lq_ptr_t;
    typedef logic [5:0]  rob_idx_t;
    typedef logic [6:0]  fwd_idx_t;   // rob index plus store-ordering bit
    typedef logic [15:0] mem_addr_t;
    typedef logic [15:0] mem_data_t;
    typedef logic [5:0]  phy_reg_t;

    parameter int alloc_lanes = 4;
    parameter int lane_w = 8;          // valid bit on top of each lane

    typedef enum logic [2:0] {
        st_idle,
        st_wait_grant,
        st_issued,
        st_mem_rdy,
        st_fwd_rdy,
        st_both_rdy,
        st_writeback
    } load_state_e;

    // modular add of two queue positions in a queue of n entries
    function automatic lq_ptr_t ptr_add(input logic [5:0] a, input logic [5:0] b,
                                        input int unsigned n);
        logic [6:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= 7'(n))
            sum = sum - 7'(n);
        return sum[4:0];
    endfunction

endpackage

// File: logic/lq_ptr_ctrl.sv
`timescale 1ns/1ns

module lq_ptr_ctrl #(
    parameter int depth = 24
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [lq_pkg::alloc_lanes*lq_pkg::lane_w-1:0]   indx_ld_al,
    input  logic                                            flsh,
    input  lq_pkg::lq_ptr_t                                 mis_pred_ld_ptr,
    input  lq_pkg::lq_ptr_t                                 cmmt_ld_ptr,
    input  logic [depth-1:0]                                occupied,
    output lq_pkg::lq_ptr_t                                 head,
    output logic [depth-1:0]                                alloc_en,
    output lq_pkg::fwd_idx_t [depth-1:0]                    alloc_idx,
    output logic [depth-1:0]                                commit_clr,
    output logic [depth-1:0]                                flush_clr,
    output logic                                            stll
);
    import lq_pkg::*;

    lq_ptr_t tail;
    lq_ptr_t lane_pos;
    lq_ptr_t commit_len, flush_len;
    lq_ptr_t commit_off, flush_off;
    logic [alloc_lanes-1:0] lane_vld;
    logic [$clog2(alloc_lanes+1)-1:0] lane_cnt;
    logic lane_run, lane_ok;
    logic cmmt;

    assign cmmt = (cmmt_ld_ptr != head);
    assign stll = occupied[tail];   // next slot still holds a live load

    // count the lanes valid from lane 0 upward and drop the group on a gap
    always_comb begin
        lane_cnt = '0;
        lane_run = 1'b1;
        lane_ok  = 1'b1;
        for (int k = 0; k < alloc_lanes; k++) begin
            lane_vld[k] = indx_ld_al[lane_w*k + lane_w - 1];
            if (lane_vld[k]) begin
                if (lane_run)
                    lane_cnt = lane_cnt + 1'b1;
                else
                    lane_ok = 1'b0;
            end else begin
                lane_run = 1'b0;
            end
        end
        if (!lane_ok)
            lane_cnt = '0;
    end

    always_comb begin
        alloc_en  = '0;
        alloc_idx = '0;
        lane_pos  = tail;
        for (int k = 0; k < alloc_lanes; k++) begin
            lane_pos = ptr_add({1'b0, tail}, 6'(k), depth);
            if (k < int'(lane_cnt)) begin
                alloc_en[lane_pos]  = 1'b1;
                alloc_idx[lane_pos] = indx_ld_al[lane_w*k +: $bits(fwd_idx_t)];
            end
        end
    end

    // commit covers head..cmmt_ld_ptr and flush covers mis_pred_ld_ptr..tail
    always_comb begin
        commit_len = ptr_add({1'b0, cmmt_ld_ptr}, 6'(depth) - {1'b0, head}, depth);
        flush_len  = ptr_add({1'b0, tail}, 6'(depth) - {1'b0, mis_pred_ld_ptr}, depth);
        commit_off = '0;
        flush_off  = '0;
        for (int i = 0; i < depth; i++) begin
            commit_off    = ptr_add(6'(i), 6'(depth) - {1'b0, head}, depth);
            flush_off     = ptr_add(6'(i), 6'(depth) - {1'b0, mis_pred_ld_ptr}, depth);
            commit_clr[i] = cmmt & (commit_off < commit_len);
            flush_clr[i]  = flsh & (flush_off < flush_len);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            head <= cmmt_ld_ptr;
            if (flsh)
                tail <= mis_pred_ld_ptr;   // drop everything younger
            else
                tail <= ptr_add({1'b0, tail}, 6'(lane_cnt), depth);
        end
    end

endmodule

// File: logic/lq_entry.sv
`timescale 1ns/1ns

module lq_entry (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc_en,
    input  lq_pkg::fwd_idx_t  alloc_idx,
    input  logic              commit_clr,
    input  logic              flush_clr,
    input  logic              mem_rd,
    input  lq_pkg::rob_idx_t  indx_ls,
    input  lq_pkg::mem_addr_t addr_ls,
    input  lq_pkg::phy_reg_t  phy_addr_ld_in,
    input  logic              done_set,
    output logic              occupied,
    output logic              addr_known,
    output logic              done,
    output lq_pkg::mem_addr_t addr,
    output lq_pkg::phy_reg_t  phy,
    output lq_pkg::fwd_idx_t  idx
);
    import lq_pkg::*;

    logic upd;

    // only the rob part of the index takes part in the match
    assign upd = mem_rd & occupied & (indx_ls == idx[$bits(rob_idx_t)-1:0]);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            occupied   <= 1'b0;
            addr_known <= 1'b0;
            done       <= 1'b0;
        end else if (flush_clr) begin
            occupied <= 1'b0;
        end else if (commit_clr) begin
            occupied   <= 1'b0;
            addr_known <= 1'b0;
            done       <= 1'b0;
        end else if (alloc_en) begin
            occupied   <= 1'b1;
            addr_known <= 1'b0;   // fresh load with nothing known yet
            done       <= 1'b0;
        end else begin
            if (upd)
                addr_known <= 1'b1;
            if (done_set)
                done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en)
            idx <= alloc_idx;
        if (upd) begin
            addr <= addr_ls;
            phy  <= phy_addr_ld_in;
        end
    end

endmodule

// File: logic/lq_issue_select.sv
`timescale 1ns/1ns

module lq_issue_select #(
    parameter int depth = 24
) (
    input  logic                             clk,
    input  logic                             rst,
    input  lq_pkg::lq_ptr_t                  head,
    input  logic [depth-1:0]                 occupied,
    input  logic [depth-1:0]                 addr_known,
    input  logic [depth-1:0]                 done,
    input  lq_pkg::mem_addr_t [depth-1:0]    ent_addr,
    input  lq_pkg::phy_reg_t [depth-1:0]     ent_phy,
    input  lq_pkg::fwd_idx_t [depth-1:0]     ent_idx,
    input  logic                             busy,
    input  logic                             finished,
    output logic                             ld_rdy,
    output logic [depth-1:0]                 done_set,
    output lq_pkg::mem_addr_t                addr,
    output lq_pkg::phy_reg_t                 phy_addr_ld,
    output lq_pkg::rob_idx_t                 indx_ld,
    output lq_pkg::fwd_idx_t                 indx_fwd
);
    import lq_pkg::*;

    logic [depth-1:0] bid;
    logic [depth-1:0] rot_bid;   // bit 0 is the head entry
    lq_ptr_t sel_off;
    lq_ptr_t current;

    assign bid    = occupied & addr_known & ~done & {depth{~busy}};
    assign ld_rdy = |bid;

    always_comb begin
        sel_off = '0;
        for (int j = 0; j < depth; j++) begin
            rot_bid[j] = bid[ptr_add({1'b0, head}, 6'(j), depth)];
        end
        // walk down so the lowest offset from head wins
        for (int j = depth - 1; j >= 0; j--) begin
            if (rot_bid[j])
                sel_off = lq_ptr_t'(j);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            current <= '0;
        else if (!busy)
            current <= ptr_add({1'b0, head}, {1'b0, sel_off}, depth);
    end

    assign done_set    = {{(depth-1){1'b0}}, finished} << current;
    assign addr        = ent_addr[current];
    assign phy_addr_ld = ent_phy[current];
    assign indx_fwd    = ent_idx[current];
    assign indx_ld     = ent_idx[current][$bits(rob_idx_t)-1:0];

endmodule

// File: logic/lq_load_ctrl.sv
`timescale 1ns/1ns

module lq_load_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              ld_rdy,
    input  logic              ld_grnt,
    input  logic              done,
    input  lq_pkg::mem_data_t data_ca,
    input  logic              fwd,
    input  logic              fwd_rdy,
    input  lq_pkg::mem_data_t data_sq,
    output logic              ld_req,
    output logic              busy,
    output logic              finished,
    output logic              vld_ld,
    output logic              reg_wrt_ld,
    output lq_pkg::mem_data_t data_ld
);
    import lq_pkg::*;

    load_state_e state, nxt_state;
    mem_data_t ca_q, sq_q;
    logic fwd_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            state <= st_idle;
        else
            state <= nxt_state;
    end

    always_comb begin
        nxt_state  = state;
        ld_req     = 1'b0;
        busy       = 1'b0;
        finished   = 1'b0;
        vld_ld     = 1'b0;
        reg_wrt_ld = 1'b0;
        case (state)
            st_idle: begin
                if (ld_rdy)
                    nxt_state = st_wait_grant;
            end
            st_wait_grant: begin
                ld_req = 1'b1;   // hold until the arbiter answers
                if (ld_grnt)
                    nxt_state = st_issued;
            end
            st_issued: begin
                busy = 1'b1;
                if (done && fwd_rdy)
                    nxt_state = st_both_rdy;
                else if (done)
                    nxt_state = st_mem_rdy;
                else if (fwd_rdy)
                    nxt_state = st_fwd_rdy;
            end
            st_mem_rdy: begin
                busy = 1'b1;
                if (fwd_rdy)
                    nxt_state = st_writeback;
            end
            st_fwd_rdy: begin
                busy = 1'b1;
                if (done)
                    nxt_state = st_writeback;
            end
            st_both_rdy: begin
                busy      = 1'b1;
                nxt_state = st_writeback;
            end
            st_writeback: begin
                busy       = 1'b1;
                finished   = 1'b1;
                vld_ld     = 1'b1;
                reg_wrt_ld = 1'b1;
                nxt_state  = st_idle;
            end
            default: nxt_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            fwd_q <= 1'b0;
        else if (fwd_rdy)
            fwd_q <= fwd;
    end

    always_ff @(posedge clk) begin
        if (done)
            ca_q <= data_ca;
        if (fwd_rdy)
            sq_q <= data_sq;
    end

    assign data_ld = fwd_q ? sq_q : ca_q;   // store queue wins on a forward hit

endmodule

// File: logic/load_queue.sv
`timescale 1ns/1ns

module load_queue #(
    parameter int depth = 24
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          flsh,
    input  lq_pkg::lq_ptr_t                               mis_pred_ld_ptr,
    input  lq_pkg::lq_ptr_t                               cmmt_ld_ptr,
    input  logic [lq_pkg::alloc_lanes*lq_pkg::lane_w-1:0] indx_ld_al,
    input  logic                                          mem_rd,
    input  lq_pkg::rob_idx_t                              indx_ls,
    input  lq_pkg::mem_addr_t                             addr_ls,
    input  lq_pkg::phy_reg_t                              phy_addr_ld_in,
    input  logic                                          ld_grnt,
    input  logic                                          done,
    input  lq_pkg::mem_data_t                             data_ca,
    input  logic                                          fwd,
    input  logic                                          fwd_rdy,
    input  lq_pkg::mem_data_t                             data_sq,
    output logic                                          stll,
    output logic                                          ld_req,
    output lq_pkg::mem_addr_t                             addr,
    output lq_pkg::phy_reg_t                              phy_addr_ld,
    output lq_pkg::rob_idx_t                              indx_ld,
    output lq_pkg::fwd_idx_t                              indx_fwd,
    output lq_pkg::mem_data_t                             data_ld,
    output logic                                          vld_ld,
    output logic                                          reg_wrt_ld
);
    import lq_pkg::*;

    lq_ptr_t head;
    logic [depth-1:0] alloc_en, commit_clr, flush_clr;
    logic [depth-1:0] occupied, addr_known, ent_done, done_set;
    fwd_idx_t [depth-1:0] alloc_idx, ent_idx;
    mem_addr_t [depth-1:0] ent_addr;
    phy_reg_t [depth-1:0] ent_phy;
    logic ld_rdy, busy, finished;

    lq_ptr_ctrl #(.depth(depth)) ptr_ctrl_i (
        .clk(clk), .rst(rst), .indx_ld_al(indx_ld_al), .flsh(flsh),
        .mis_pred_ld_ptr(mis_pred_ld_ptr), .cmmt_ld_ptr(cmmt_ld_ptr),
        .occupied(occupied), .head(head), .alloc_en(alloc_en), .alloc_idx(alloc_idx),
        .commit_clr(commit_clr), .flush_clr(flush_clr), .stll(stll)
    );

    for (genvar g = 0; g < depth; g++) begin : g_entry
        lq_entry entry_i (
            .clk(clk), .rst(rst), .alloc_en(alloc_en[g]), .alloc_idx(alloc_idx[g]),
            .commit_clr(commit_clr[g]), .flush_clr(flush_clr[g]), .mem_rd(mem_rd),
            .indx_ls(indx_ls), .addr_ls(addr_ls), .phy_addr_ld_in(phy_addr_ld_in),
            .done_set(done_set[g]), .occupied(occupied[g]), .addr_known(addr_known[g]),
            .done(ent_done[g]), .addr(ent_addr[g]), .phy(ent_phy[g]), .idx(ent_idx[g])
        );
    end

    lq_issue_select #(.depth(depth)) issue_select_i (
        .clk(clk), .rst(rst), .head(head), .occupied(occupied), .addr_known(addr_known),
        .done(ent_done), .ent_addr(ent_addr), .ent_phy(ent_phy), .ent_idx(ent_idx),
        .busy(busy), .finished(finished), .ld_rdy(ld_rdy), .done_set(done_set),
        .addr(addr), .phy_addr_ld(phy_addr_ld), .indx_ld(indx_ld), .indx_fwd(indx_fwd)
    );

    lq_load_ctrl load_ctrl_i (
        .clk(clk), .rst(rst), .ld_rdy(ld_rdy), .ld_grnt(ld_grnt), .done(done),
        .data_ca(data_ca), .fwd(fwd), .fwd_rdy(fwd_rdy), .data_sq(data_sq),
        .ld_req(ld_req), .busy(busy), .finished(finished), .vld_ld(vld_ld),
        .reg_wrt_ld(reg_wrt_ld), .data_ld(data_ld)
    );

endmodule

// File: dv/tb_load_queue.sv
`timescale 1ns/1ns

module tb_load_queue;
    import lq_pkg::*;

    localparam int depth = 24;
    localparam int n_rows = 6;
    localparam int timeout_cycles = n_rows * 60;
    localparam int k_reset = 0;
    localparam int k_load = 1;
    localparam int k_stall = 2;
    localparam int k_flush = 3;

    typedef struct {
        string name;
        int kind;
        int lanes;
        fwd_idx_t [3:0] idx;     // lane 0 in slot 0
        mem_addr_t [1:0] addr;
        phy_reg_t [1:0] phy;
        logic fwd;
        int order;               // 0 done first, 1 fwd_rdy first, 2 together
    } test_row_t;

    logic clk, rst, flsh, mem_rd, ld_grnt, done, fwd, fwd_rdy;
    lq_ptr_t mis_pred_ld_ptr, cmmt_ld_ptr;
    logic [alloc_lanes*lane_w-1:0] indx_ld_al;
    rob_idx_t indx_ls, indx_ld;
    mem_addr_t addr_ls, addr;
    phy_reg_t phy_addr_ld_in, phy_addr_ld;
    mem_data_t data_ca, data_sq, data_ld;
    fwd_idx_t indx_fwd;
    logic stll, ld_req, vld_ld, reg_wrt_ld;

    test_row_t rows [n_rows];
    integer seed;
    int errors = 0;
    int checks = 0;
    int cycle_cnt = 0;
    int head_m = 0;   // queue pointers as the testbench expects them
    int tail_m = 0;
    string cur_test = "";
    string waiting_on = "reset";

    load_queue #(.depth(depth)) load_queue_i (
        .clk(clk), .rst(rst), .flsh(flsh), .mis_pred_ld_ptr(mis_pred_ld_ptr),
        .cmmt_ld_ptr(cmmt_ld_ptr), .indx_ld_al(indx_ld_al), .mem_rd(mem_rd),
        .indx_ls(indx_ls), .addr_ls(addr_ls), .phy_addr_ld_in(phy_addr_ld_in),
        .ld_grnt(ld_grnt), .done(done), .data_ca(data_ca), .fwd(fwd), .fwd_rdy(fwd_rdy),
        .data_sq(data_sq), .stll(stll), .ld_req(ld_req), .addr(addr),
        .phy_addr_ld(phy_addr_ld), .indx_ld(indx_ld), .indx_fwd(indx_fwd),
        .data_ld(data_ld), .vld_ld(vld_ld), .reg_wrt_ld(reg_wrt_ld)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout after %0d cycles in %s while waiting for %s",
                     cycle_cnt, cur_test, waiting_on);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic build_table();
        rows[0] = '{"reset", k_reset, 0, '0, '0, '0, 1'b0, 0};
        rows[1] = '{"cache_only", k_load, 1, {7'h00, 7'h00, 7'h00, 7'h05},
                    {16'h0000, 16'h1a40}, {6'd0, 6'd17}, 1'b0, 0};
        rows[2] = '{"forwarded", k_load, 1, {7'h00, 7'h00, 7'h00, 7'h49},
                    {16'h0000, 16'h2c08}, {6'd0, 6'd33}, 1'b1, 1};
        rows[3] = '{"oldest_first", k_load, 2, {7'h00, 7'h00, 7'h12, 7'h11},
                    {16'h5550, 16'h3f00}, {6'd44, 6'd12}, 1'b0, 2};
        rows[4] = '{"stall_commit", k_stall, 4, {7'h23, 7'h22, 7'h21, 7'h20},
                    '0, '0, 1'b0, 0};
        rows[5] = '{"flush", k_flush, 4, {7'h33, 7'h32, 7'h31, 7'h30},
                    {16'h0000, 16'h7e10}, {6'd0, 6'd21}, 1'b0, 0};
    endtask

    task automatic check_val(input string field, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        checks++;
        assert (exp_v === act_v) else begin
            errors++;
            $display("Mismatch in %s, %s: expected %0h, actual %0h",
                     cur_test, field, exp_v, act_v);
        end
    endtask

    // same lane group on consecutive cycles
    task automatic allocate(input int r, input int cycles);
        logic [alloc_lanes*lane_w-1:0] word;
        word = '0;
        for (int k = 0; k < rows[r].lanes; k++)
            word[lane_w*k +: lane_w] = {1'b1, rows[r].idx[k]};
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            indx_ld_al <= word;
        end
        @(posedge clk);
        indx_ld_al <= '0;
        tail_m = (tail_m + cycles * rows[r].lanes) % depth;
    endtask

    task automatic update_addr(input rob_idx_t idx, input mem_addr_t a, input phy_reg_t p);
        @(posedge clk);
        mem_rd <= 1'b1;
        indx_ls <= idx;
        addr_ls <= a;
        phy_addr_ld_in <= p;
        @(posedge clk);
        mem_rd <= 1'b0;
    endtask

    task automatic commit_to(input int ptr);
        @(posedge clk);
        cmmt_ld_ptr <= lq_ptr_t'(ptr % depth);
        head_m = ptr % depth;
        @(posedge clk);
    endtask

    task automatic serve_load(input int r, input int lane);
        mem_data_t ca;
        mem_data_t sq;
        mem_data_t exp_data;
        ca = mem_data_t'($random(seed));
        sq = mem_data_t'($random(seed));
        exp_data = rows[r].fwd ? sq : ca;   // forward hit returns store data
        waiting_on = "ld_req";
        @(negedge clk);
        while (!ld_req)
            @(negedge clk);
        @(posedge clk);
        ld_grnt <= 1'b1;
        @(negedge clk);
        check_val("addr at grant", rows[r].addr[lane], addr);
        @(posedge clk);
        ld_grnt <= 1'b0;
        done <= (rows[r].order != 1);
        fwd_rdy <= (rows[r].order != 0);
        data_ca <= ca;
        data_sq <= sq;
        fwd <= rows[r].fwd;
        @(posedge clk);
        done <= (rows[r].order == 1);   // second strobe when they come apart
        fwd_rdy <= (rows[r].order == 0);
        if (rows[r].order != 2) begin
            @(posedge clk);
            done <= 1'b0;
            fwd_rdy <= 1'b0;
        end
        waiting_on = "vld_ld";
        @(negedge clk);
        while (!vld_ld)
            @(negedge clk);
        check_val("data_ld", exp_data, data_ld);
        check_val("reg_wrt_ld", 1, reg_wrt_ld);
        check_val("addr", rows[r].addr[lane], addr);
        check_val("phy_addr_ld", rows[r].phy[lane], phy_addr_ld);
        check_val("indx_ld", rows[r].idx[lane][5:0], indx_ld);
        check_val("indx_fwd", rows[r].idx[lane], indx_fwd);
        @(negedge clk);
        check_val("vld_ld after writeback", 0, vld_ld);
        check_val("reg_wrt_ld after writeback", 0, reg_wrt_ld);
    endtask

    task automatic run_loads(input int r);
        allocate(r, 1);
        for (int k = rows[r].lanes - 1; k >= 0; k--)   // youngest address first
            update_addr(rows[r].idx[k][5:0], rows[r].addr[k], rows[r].phy[k]);
        for (int k = 0; k < rows[r].lanes; k++)
            serve_load(r, k);
    endtask

    task automatic run_stall(input int r);
        allocate(r, depth / alloc_lanes);
        @(negedge clk);
        check_val("stll when full", 1, stll);
        commit_to(head_m + 4);
        @(negedge clk);
        check_val("stll after commit", 0, stll);
        commit_to(tail_m);
    endtask

    task automatic run_flush(input int r);
        int start;
        int req_seen;
        start = tail_m;
        allocate(r, 1);
        @(posedge clk);
        flsh <= 1'b1;
        mis_pred_ld_ptr <= lq_ptr_t'((start + 1) % depth);
        @(posedge clk);
        flsh <= 1'b0;
        tail_m = (start + 1) % depth;
        update_addr(rows[r].idx[2][5:0], rows[r].addr[0], rows[r].phy[0]);
        req_seen = 0;
        repeat (20) begin
            @(negedge clk);
            if (ld_req)
                req_seen++;
        end
        checks++;
        assert (req_seen == 0) else begin
            errors++;
            $display("%s: ld_req went high for a flushed load", cur_test);
        end
    endtask

    initial begin
        int errs_before;
        seed = 32'h92d5;
        build_table();
        rst = 1'b0;
        flsh = 1'b0;
        mis_pred_ld_ptr = '0;
        cmmt_ld_ptr = '0;
        indx_ld_al = '0;
        mem_rd = 1'b0;
        indx_ls = '0;
        addr_ls = '0;
        phy_addr_ld_in = '0;
        ld_grnt = 1'b0;
        done = 1'b0;
        data_ca = '0;
        fwd = 1'b0;
        fwd_rdy = 1'b0;
        data_sq = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        for (int t = 0; t < n_rows; t++) begin
            cur_test = rows[t].name;
            errs_before = errors;
            case (rows[t].kind)
                k_reset: begin
                    @(negedge clk);
                    check_val("ld_req", 0, ld_req);
                    check_val("vld_ld", 0, vld_ld);
                    check_val("reg_wrt_ld", 0, reg_wrt_ld);
                    check_val("stll", 0, stll);
                end
                k_load:  run_loads(t);
                k_stall: run_stall(t);
                default: run_flush(t);
            endcase
            if (tail_m != head_m)
                commit_to(tail_m);   // retire what is left
            $display("test %s finished with %0d errors", cur_test, errors - errs_before);
        end
        $display("%0d tests, %0d checks, %0d errors", n_rows, checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: sources.f
logic/lq_pkg.sv
logic/lq_ptr_ctrl.sv
logic/lq_entry.sv
logic/lq_issue_select.sv
logic/lq_load_ctrl.sv
logic/load_queue.sv
dv/tb_load_queue.sv

// File: Makefile
TOP = tb_load_queue

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
